// File: flist.f
+incdir+hw
hw/arch_defs_pkg.sv
hw/uart_rx_if.sv
hw/uart_receiver.sv
hw/uart_transmitter.sv
hw/uart_peripheral.sv
test/uart_tb.sv

// File: test/uart_tb.sv
`default_nettype none

`include "uart_consts.svh"

module uart_tb
    import arch_defs_pkg::*;
();

    localparam int W          = `UART_DATA_WIDTH;
    localparam int POLL_LIMIT = 400;
    localparam int MAX_STEPS  = 32;

    // Status bits as the register map defines them
    localparam logic [W-1:0] ST_TX_EMPTY = 8'h01;
    localparam logic [W-1:0] ST_RX_READY = 8'h02;
    localparam logic [W-1:0] ST_FRAME    = 8'h04;
    localparam logic [W-1:0] ST_OVERRUN  = 8'h08;

    typedef enum logic [2:0] {
        OP_WRITE,
        OP_READ,
        OP_SEND,
        OP_WAIT_READY,
        OP_WAIT_IDLE
    } op_e;

    typedef struct packed {
        op_e              op;
        uart_reg_offset_e offset;
        logic [W-1:0]     data;
        logic             stop_bit;
        logic [W-1:0]     expected;
        logic [W-1:0]     mask;
    } step_t;

    logic             clk;
    logic             reset;
    uart_reg_offset_e address_offset_i;
    logic             cmd_enable_i;
    logic             cmd_write_i;
    logic             cmd_read_i;
    logic [W-1:0]     parallel_data_i;
    logic [W-1:0]     parallel_data_o;
    logic             serial_rx_i;
    logic             serial_tx_o;

    step_t  steps [0:MAX_STEPS-1];
    int     step_count;
    integer seed;

    uart_peripheral uart_peripheral_i (
        .clk              (clk),
        .reset            (reset),
        .address_offset_i (address_offset_i),
        .cmd_enable_i     (cmd_enable_i),
        .cmd_write_i      (cmd_write_i),
        .cmd_read_i       (cmd_read_i),
        .parallel_data_i  (parallel_data_i),
        .parallel_data_o  (parallel_data_o),
        .serial_rx_i      (serial_rx_i),
        .serial_tx_o      (serial_tx_o)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ==============================
    // Checking
    // ==============================

    task automatic abort_run(input string why);
        $display("=== FAIL ===");
        $fatal(1, "%s", why);
    endtask

    task automatic compare_word(input string name, input logic [W-1:0] expected,
                                input logic [W-1:0] actual);
        if (actual !== expected) begin
            $display("FAIL time=%0t %s expected=%h actual=%h", $time, name, expected, actual);
            abort_run("register word mismatch");
        end
    endtask

    task automatic compare_line(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("FAIL time=%0t %s expected=%b actual=%b", $time, name, expected, actual);
            abort_run("serial line mismatch");
        end
    endtask

    function automatic string reg_name(input uart_reg_offset_e offset);
        case (offset)
            UART_REG_CONTROL: return "parallel_data_o(CONTROL)";
            UART_REG_STATUS:  return "parallel_data_o(STATUS)";
            UART_REG_DATA:    return "parallel_data_o(DATA)";
            default:          return "parallel_data_o(unmapped)";
        endcase
    endfunction

    // ==============================
    // Bus and serial drivers
    // ==============================

    task automatic bus_write(input uart_reg_offset_e offset, input logic [W-1:0] value);
        @(posedge clk);
        #10;
        cmd_enable_i     = 1'b1;
        cmd_write_i      = 1'b1;
        address_offset_i = offset;
        parallel_data_i  = value;
        @(posedge clk);
        #10;
        cmd_enable_i = 1'b0;
        cmd_write_i  = 1'b0;
    endtask

    // Read data is combinational, sampled late in the cycle
    task automatic bus_read(input uart_reg_offset_e offset, output logic [W-1:0] value);
        @(posedge clk);
        #10;
        cmd_enable_i     = 1'b1;
        cmd_read_i       = 1'b1;
        address_offset_i = offset;
        #80;
        value = parallel_data_o;
        @(posedge clk);
        #10;
        cmd_enable_i = 1'b0;
        cmd_read_i   = 1'b0;
    endtask

    // Start bit, LSB first data, then the given stop bit
    task automatic send_frame(input logic [W-1:0] value, input logic stop_bit);
        logic [W+1:0] frame;
        frame = {stop_bit, value, 1'b0};
        for (int i = 0; i < W + 2; i++) begin
            for (int c = 0; c < `UART_CLKS_PER_BIT; c++) begin
                @(posedge clk);
                #10;
                serial_rx_i = frame[i];
                // Nothing is being sent while bytes come in
                compare_line("serial_tx_o", 1'b1, serial_tx_o);
            end
        end
        @(posedge clk);
        #10;
        serial_rx_i = 1'b1;
    endtask

    task automatic wait_status(input int bit_idx, input string what, output logic [W-1:0] st);
        int   polls;
        logic done;
        polls = 0;
        done  = 1'b0;
        while (!done) begin
            bus_read(UART_REG_STATUS, st);
            if (st[bit_idx]) begin
                done = 1'b1;
            end else begin
                polls++;
                if (polls >= POLL_LIMIT) begin
                    abort_run($sformatf("timed out waiting for %s after %0d STATUS reads",
                                        what, POLL_LIMIT));
                end
            end
        end
    endtask

    task automatic add_step(input op_e op, input uart_reg_offset_e offset,
                            input logic [W-1:0] data, input logic stop_bit,
                            input logic [W-1:0] expected, input logic [W-1:0] mask);
        steps[step_count] = '{op, offset, data, stop_bit, expected, mask};
        step_count++;
    endtask

    // ==============================
    // Main sequence
    // ==============================

    initial begin
        logic [W-1:0] rd;
        logic [W-1:0] lb_byte;
        logic [W-1:0] ext_byte;
        logic [W-1:0] bad_byte;
        logic [W-1:0] first_byte;
        logic [W-1:0] second_byte;
        step_t        s;

        reset            = 1'b1;
        address_offset_i = UART_REG_CONTROL;
        cmd_enable_i     = 1'b0;
        cmd_write_i      = 1'b0;
        cmd_read_i       = 1'b0;
        parallel_data_i  = '0;
        serial_rx_i      = 1'b1;
        step_count       = 0;
        seed             = 7;

        lb_byte     = W'($random(seed));
        ext_byte    = W'($random(seed));
        bad_byte    = W'($random(seed));
        first_byte  = W'($random(seed));
        second_byte = W'($random(seed));

        // Reset state
        add_step(OP_READ, UART_REG_STATUS, 8'h00, 1'b1, ST_TX_EMPTY, 8'hFF);
        add_step(OP_READ, UART_REG_CONTROL, 8'h00, 1'b1, 8'h00, 8'hFF);
        // Control read back
        add_step(OP_WRITE, UART_REG_CONTROL, 8'h5A, 1'b1, 8'h00, 8'h00);
        add_step(OP_READ, UART_REG_CONTROL, 8'h00, 1'b1, 8'h5A, 8'hFF);
        // Loopback clears TX empty while sending
        add_step(OP_WRITE, UART_REG_CONTROL, 8'h01, 1'b1, 8'h00, 8'h00);
        add_step(OP_WRITE, UART_REG_DATA, lb_byte, 1'b1, 8'h00, 8'h00);
        add_step(OP_READ, UART_REG_STATUS, 8'h00, 1'b1, 8'h00, 8'hFF);
        add_step(OP_WAIT_READY, UART_REG_STATUS, 8'h00, 1'b1, ST_RX_READY, 8'h0E);
        add_step(OP_WAIT_IDLE, UART_REG_STATUS, 8'h00, 1'b1,
                 ST_TX_EMPTY | ST_RX_READY, 8'hFF);
        add_step(OP_READ, UART_REG_DATA, 8'h00, 1'b1, lb_byte, 8'hFF);
        add_step(OP_READ, UART_REG_STATUS, 8'h00, 1'b1, ST_TX_EMPTY, 8'hFF);
        add_step(OP_WRITE, UART_REG_CONTROL, 8'h00, 1'b1, 8'h00, 8'h00);
        // External receive
        add_step(OP_SEND, UART_REG_DATA, ext_byte, 1'b1, 8'h00, 8'h00);
        add_step(OP_WAIT_READY, UART_REG_STATUS, 8'h00, 1'b1,
                 ST_TX_EMPTY | ST_RX_READY, 8'hFF);
        add_step(OP_READ, UART_REG_DATA, 8'h00, 1'b1, ext_byte, 8'hFF);
        // Frame error flag clears on the status read
        add_step(OP_SEND, UART_REG_DATA, bad_byte, 1'b0, 8'h00, 8'h00);
        add_step(OP_READ, UART_REG_STATUS, 8'h00, 1'b1, ST_TX_EMPTY | ST_FRAME, 8'hFF);
        add_step(OP_READ, UART_REG_STATUS, 8'h00, 1'b1, ST_TX_EMPTY, 8'hFF);
        // Overrun keeps the first byte
        add_step(OP_SEND, UART_REG_DATA, first_byte, 1'b1, 8'h00, 8'h00);
        add_step(OP_SEND, UART_REG_DATA, second_byte, 1'b1, 8'h00, 8'h00);
        add_step(OP_WAIT_READY, UART_REG_STATUS, 8'h00, 1'b1,
                 ST_TX_EMPTY | ST_RX_READY | ST_OVERRUN, 8'hFF);
        add_step(OP_READ, UART_REG_DATA, 8'h00, 1'b1, first_byte, 8'hFF);
        add_step(OP_READ, UART_REG_STATUS, 8'h00, 1'b1, ST_TX_EMPTY, 8'hFF);

        repeat (16) @(posedge clk);
        #10;
        reset = 1'b0;
        compare_line("serial_tx_o", 1'b1, serial_tx_o);

        for (int i = 0; i < step_count; i++) begin
            s = steps[i];
            case (s.op)
                OP_WRITE: begin
                    bus_write(s.offset, s.data);
                end
                OP_READ: begin
                    bus_read(s.offset, rd);
                    compare_word(reg_name(s.offset), s.expected & s.mask, rd & s.mask);
                end
                OP_SEND: begin
                    send_frame(s.data, s.stop_bit);
                end
                OP_WAIT_READY: begin
                    wait_status(1, "RX ready", rd);
                    compare_word(reg_name(s.offset), s.expected & s.mask, rd & s.mask);
                end
                OP_WAIT_IDLE: begin
                    wait_status(0, "TX empty", rd);
                    compare_word(reg_name(s.offset), s.expected & s.mask, rd & s.mask);
                end
                default: begin
                    abort_run("unknown step kind in stimulus table");
                end
            endcase
        end

        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire

// File: hw/uart_peripheral.sv
`default_nettype none

`include "uart_consts.svh"

module uart_peripheral
    import arch_defs_pkg::*;
(
    input  logic                        clk,
    input  logic                        reset,

    input  uart_reg_offset_e            address_offset_i,

    // Bus strobes
    input  logic                        cmd_enable_i,
    input  logic                        cmd_write_i,
    input  logic                        cmd_read_i,

    input  logic [`UART_DATA_WIDTH-1:0] parallel_data_i,
    output logic [`UART_DATA_WIDTH-1:0] parallel_data_o,

    // Serial pins
    input  logic                        serial_rx_i,
    output logic                        serial_tx_o
);

    localparam int STAT_TX_EMPTY = 0;
    localparam int STAT_RX_READY = 1;
    localparam int STAT_FRAME    = 2;
    localparam int STAT_OVERRUN  = 3;
    localparam int CTRL_LOOPBACK = 0;

    logic [`UART_DATA_WIDTH-1:0] control_q;
    logic [`UART_DATA_WIDTH-1:0] control_next;
    logic [`UART_DATA_WIDTH-1:0] status_word;

    logic tx_start;
    logic tx_busy;
    logic tx_serial;
    logic rx_serial;
    logic data_ack;
    logic status_ack;

    uart_rx_if rx_bus ();

    // ============================
    // Receiver and loopback
    // ============================

    assign rx_serial = control_q[CTRL_LOOPBACK] ? tx_serial : serial_rx_i;

    uart_receiver u_receiver (
        .clk      (clk),
        .reset    (reset),
        .serial_i (rx_serial),
        .rx       (rx_bus.receiver)
    );

    assign rx_bus.data_ack   = data_ack;
    assign rx_bus.status_ack = status_ack;

    // ============================
    // Transmitter
    // ============================

    // Pin still carries the frame in loopback
    uart_transmitter u_transmitter (
        .clk        (clk),
        .reset      (reset),
        .tx_data_i  (parallel_data_i),
        .tx_start_i (tx_start),
        .tx_busy_o  (tx_busy),
        .serial_o   (tx_serial)
    );

    assign serial_tx_o = tx_serial;

    // ============================
    // Register decode
    // ============================

    always_comb begin
        status_word                = '0;
        status_word[STAT_TX_EMPTY] = ~tx_busy;
        status_word[STAT_RX_READY] = rx_bus.ready;
        status_word[STAT_FRAME]    = rx_bus.frame_err;
        status_word[STAT_OVERRUN]  = rx_bus.overrun;
    end

    // Write wins over read on the same access
    always_comb begin
        control_next    = control_q;
        parallel_data_o = '0;
        tx_start        = 1'b0;
        data_ack        = 1'b0;
        status_ack      = 1'b0;

        if (cmd_enable_i) begin
            case (address_offset_i)
                UART_REG_CONTROL: begin
                    if (cmd_write_i) begin
                        control_next = parallel_data_i;
                    end else if (cmd_read_i) begin
                        parallel_data_o = control_q;
                    end
                end
                UART_REG_STATUS: begin
                    // Reading status clears the error flags
                    if (!cmd_write_i && cmd_read_i) begin
                        parallel_data_o = status_word;
                        status_ack      = 1'b1;
                    end
                end
                UART_REG_DATA: begin
                    if (cmd_write_i) begin
                        tx_start = 1'b1;
                    end else if (cmd_read_i) begin
                        parallel_data_o = rx_bus.data;
                        data_ack        = 1'b1;
                    end
                end
                default: begin
                    parallel_data_o = '0;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            control_q <= '0;
        end else begin
            control_q <= control_next;
        end
    end

    a_bus_single_cmd: assert property (
        @(posedge clk) disable iff (reset)
        cmd_enable_i |-> !(cmd_write_i && cmd_read_i)
    );

endmodule

`default_nettype wire

// File: hw/uart_transmitter.sv
`default_nettype none

`include "uart_consts.svh"

module uart_transmitter
    import arch_defs_pkg::*;
(
    input  logic                        clk,
    input  logic                        reset,
    input  logic [`UART_DATA_WIDTH-1:0] tx_data_i,
    input  logic                        tx_start_i,
    output logic                        tx_busy_o,
    output logic                        serial_o
);

    localparam int CNT_W = $clog2(`UART_CLKS_PER_BIT);
    localparam int BIT_W = $clog2(`UART_DATA_WIDTH);

    localparam logic [CNT_W-1:0] LAST_CYCLE = CNT_W'(`UART_CLKS_PER_BIT - 1);
    localparam logic [BIT_W-1:0] LAST_BIT   = BIT_W'(`UART_DATA_WIDTH - 1);

    tx_state_e                   state;
    logic [CNT_W-1:0]            cycle_cnt;
    logic [BIT_W-1:0]            bit_cnt;
    logic [`UART_DATA_WIDTH-1:0] shift_q;
    logic                        serial_q;
    logic                        bit_tick;
    logic                        accept;

    assign bit_tick  = (cycle_cnt == LAST_CYCLE);
    // Starts while busy are dropped here
    assign accept    = tx_start_i && (state == TX_IDLE);
    assign tx_busy_o = (state != TX_IDLE);
    assign serial_o  = serial_q;

    // ============================
    // Frame FSM
    // ============================

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= TX_IDLE;
            cycle_cnt <= '0;
            bit_cnt   <= '0;
            serial_q  <= 1'b1;
        end else begin
            case (state)
                TX_IDLE: begin
                    cycle_cnt <= '0;
                    bit_cnt   <= '0;
                    if (accept) begin
                        state    <= TX_START;
                        serial_q <= 1'b0;
                    end
                end
                TX_START: begin
                    if (bit_tick) begin
                        cycle_cnt <= '0;
                        serial_q  <= shift_q[0];
                        state     <= TX_DATA;
                    end else begin
                        cycle_cnt <= cycle_cnt + 1'b1;
                    end
                end
                TX_DATA: begin
                    if (bit_tick) begin
                        cycle_cnt <= '0;
                        if (bit_cnt == LAST_BIT) begin
                            serial_q <= 1'b1;
                            state    <= TX_STOP;
                        end else begin
                            bit_cnt  <= bit_cnt + 1'b1;
                            serial_q <= shift_q[1];
                        end
                    end else begin
                        cycle_cnt <= cycle_cnt + 1'b1;
                    end
                end
                TX_STOP: begin
                    // Busy falls at the edge that ends the stop bit
                    if (bit_tick) begin
                        cycle_cnt <= '0;
                        state     <= TX_IDLE;
                    end else begin
                        cycle_cnt <= cycle_cnt + 1'b1;
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    // Shift right once per data bit so bit 0 is always next
    always_ff @(posedge clk) begin
        if (accept) begin
            shift_q <= tx_data_i;
        end else if ((state == TX_DATA) && bit_tick) begin
            shift_q <= shift_q >> 1;
        end
    end

    a_idle_line_high: assert property (
        @(posedge clk) disable iff (reset)
        (state == TX_IDLE) |-> serial_o
    );

endmodule

`default_nettype wire

// File: hw/uart_receiver.sv
`default_nettype none

`include "uart_consts.svh"

module uart_receiver
    import arch_defs_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        serial_i,
    uart_rx_if.receiver rx
);

    localparam int CNT_W = $clog2(`UART_CLKS_PER_BIT);
    // One extra bit so the counter range can be checked
    localparam int BIT_W = $clog2(`UART_DATA_WIDTH + 1);

    localparam logic [CNT_W-1:0] LAST_CYCLE = CNT_W'(`UART_CLKS_PER_BIT - 1);
    localparam logic [CNT_W-1:0] HALF_CYCLE = CNT_W'(`UART_CLKS_PER_BIT / 2 - 1);
    localparam logic [BIT_W-1:0] LAST_BIT   = BIT_W'(`UART_DATA_WIDTH - 1);

    rx_state_e                   state;
    logic [CNT_W-1:0]            cycle_cnt;
    logic [BIT_W-1:0]            bit_cnt;
    logic [2:0]                  sync_q;
    logic [`UART_DATA_WIDTH-1:0] shift_q;

    logic rx_line;
    logic start_edge;
    logic bit_tick;
    logic stop_sample;
    logic frame_done;
    logic frame_bad;
    logic holding;

    // ============================
    // Line synchronizer
    // ============================

    // Two flops for metastability, a third for edge detection
    always_ff @(posedge clk) begin
        if (reset) begin
            sync_q <= 3'b111;
        end else begin
            sync_q <= {sync_q[1:0], serial_i};
        end
    end

    assign rx_line    = sync_q[1];
    assign start_edge = sync_q[2] & ~sync_q[1];

    assign bit_tick    = (cycle_cnt == LAST_CYCLE);
    assign stop_sample = (state == RX_STOP) && bit_tick;
    assign frame_done  = stop_sample && rx_line;
    assign frame_bad   = stop_sample && !rx_line;

    // A byte being read this cycle frees the holding register
    assign holding = rx.ready && !rx.data_ack;

    // ============================
    // Frame FSM
    // ============================

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= RX_IDLE;
            cycle_cnt <= '0;
            bit_cnt   <= '0;
        end else begin
            case (state)
                RX_IDLE: begin
                    cycle_cnt <= '0;
                    bit_cnt   <= '0;
                    if (start_edge) begin
                        state <= RX_START;
                    end
                end
                RX_START: begin
                    // Confirm the start bit at its middle to reject glitches
                    if (cycle_cnt == HALF_CYCLE) begin
                        cycle_cnt <= '0;
                        state     <= rx_line ? RX_IDLE : RX_DATA;
                    end else begin
                        cycle_cnt <= cycle_cnt + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (bit_tick) begin
                        cycle_cnt <= '0;
                        if (bit_cnt == LAST_BIT) begin
                            state <= RX_STOP;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end else begin
                        cycle_cnt <= cycle_cnt + 1'b1;
                    end
                end
                RX_STOP: begin
                    if (bit_tick) begin
                        cycle_cnt <= '0;
                        state     <= RX_IDLE;
                    end else begin
                        cycle_cnt <= cycle_cnt + 1'b1;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // LSB arrives first
    always_ff @(posedge clk) begin
        if ((state == RX_DATA) && bit_tick) begin
            shift_q <= {rx_line, shift_q[`UART_DATA_WIDTH-1:1]};
        end
    end

    always_ff @(posedge clk) begin
        if (frame_done && !holding) begin
            rx.data <= shift_q;
        end
    end

    // ============================
    // Sticky flags
    // ============================

    always_ff @(posedge clk) begin
        if (reset) begin
            rx.ready     <= 1'b0;
            rx.frame_err <= 1'b0;
            rx.overrun   <= 1'b0;
        end else begin
            if (frame_done && !holding) begin
                rx.ready <= 1'b1;
            end else if (rx.data_ack) begin
                rx.ready <= 1'b0;
            end

            // New events win over a clearing status read
            if (frame_bad) begin
                rx.frame_err <= 1'b1;
            end else if (rx.status_ack) begin
                rx.frame_err <= 1'b0;
            end

            if (frame_done && holding) begin
                rx.overrun <= 1'b1;
            end else if (rx.status_ack) begin
                rx.overrun <= 1'b0;
            end
        end
    end

    a_ready_frame_err_excl: assert property (
        @(posedge clk) disable iff (reset)
        !($rose(rx.ready) && $rose(rx.frame_err))
    );

    a_bit_cnt_range: assert property (
        @(posedge clk) disable iff (reset)
        (state == RX_DATA) |-> (bit_cnt < BIT_W'(`UART_DATA_WIDTH))
    );

endmodule

`default_nettype wire

// File: hw/uart_rx_if.sv
`default_nettype none

`include "uart_consts.svh"

interface uart_rx_if;

    // Received byte and sticky flags from the receiver
    logic [`UART_DATA_WIDTH-1:0] data;
    logic                        ready;
    logic                        frame_err;
    logic                        overrun;

    // Single-cycle acknowledges from the register block
    logic                        data_ack;
    logic                        status_ack;

    modport receiver (
        output data, ready, frame_err, overrun,
        input  data_ack, status_ack
    );

    modport regs (
        input  data, ready, frame_err, overrun,
        output data_ack, status_ack
    );

endinterface

`default_nettype wire

// File: hw/arch_defs_pkg.sv
`default_nettype none

package arch_defs_pkg;

    // ============================
    // Register map
    // ============================

    // Offset 3 is unmapped and reads zero
    typedef enum logic [1:0] {
        UART_REG_CONTROL = 2'd0,
        UART_REG_STATUS  = 2'd1,
        UART_REG_DATA    = 2'd2
    } uart_reg_offset_e;

    // ============================
    // Serial engine states
    // ============================

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_e;

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_e;

endpackage

`default_nettype wire

// File: hw/uart_consts.svh
`ifndef UART_CONSTS_SVH
`define UART_CONSTS_SVH

// ============================
// UART build constants
// ============================

// Bus data width and character size
`define UART_DATA_WIDTH 8

// Clock cycles per serial bit, 4 or more
`define UART_CLKS_PER_BIT 16

`endif
